// ==== sources.f ====
+incdir+source
source/conv_pkg.sv
source/coef_memory.sv
source/window_buffer.sv
source/mac_unit.sv
source/bias_accumulator.sv
source/conv_layer_top.sv
sim/conv_layer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_layer_tb -f sources.f -o conv_layer_sim

output=$(./obj_dir/conv_layer_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qF "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// ==== sim/conv_layer_tb.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_layer_tb;
	import conv_pkg::*;

	localparam int NUM_TESTS        = 5;
	localparam int PIXELS_PER_TEST  = `IFM_DEPTH * `IFM_SIZE * `IFM_SIZE;
	localparam int OUTPUTS_PER_TEST = OUT_SIZE * OUT_SIZE;
	localparam int LOAD_CYCLES      = NUM_TESTS * (2 * WIN_TAPS * `IFM_DEPTH + `NUM_FILTERS);
	localparam int TIMEOUT_CYCLES   = 4 * NUM_TESTS * (PIXELS_PER_TEST + OUTPUTS_PER_TEST)
		+ LOAD_CYCLES;
	localparam int EXP_MAX          = 64;
	localparam longint OUT_MAX      = (longint'(1) << (`DATA_WIDTH - 1)) - 1;

	logic                          clk;
	logic                          rst_n;
	logic                          host_we;
	host_addr_u                    host_addr;
	logic signed [`DATA_WIDTH-1:0] host_data;
	logic [FILTER_WIDTH-1:0]       filter_sel;
	logic                          in_valid;
	logic signed [`DATA_WIDTH-1:0] in_pixel;
	logic                          out_credit;
	logic                          in_credit;
	logic                          out_valid;
	logic signed [`DATA_WIDTH-1:0] out_data;

	integer seed = 61;
	string  test_name = "reset";
	int     pix [`IFM_DEPTH][`IFM_SIZE][`IFM_SIZE];
	int     wt [`IFM_DEPTH][WIN_TAPS];
	int     bias_val;
	logic signed [`DATA_WIDTH-1:0] exp_mem [EXP_MAX];
	int     exp_wr = 0;
	int     exp_rd = 0;
	int     checked = 0;
	int     errors = 0;
	int     tests_run = 0;
	int     err_start;
	int     chk_start;
	int     up_credits;
	int     ds_credits;
	int     credit_pulses = 0;
	int     pixels_sent = 0;
	int     owed = 0;
	int     cycle_count = 0;
	logic   bp_mode = 1'b0;
	logic   gap_mode = 1'b0;

	conv_layer_top conv_layer_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_data(host_data),
		.filter_sel(filter_sel),
		.in_valid(in_valid),
		.in_pixel(in_pixel),
		.out_credit(out_credit),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	always #4 clk = ~clk;

	// Credit views of both streams, updated like any other flop
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			up_credits <= `IN_CREDITS;
			ds_credits <= `OUT_CREDITS;
		end
		else
		begin
			up_credits <= up_credits + (in_credit ? 1 : 0) - (in_valid ? 1 : 0);
			ds_credits <= ds_credits + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
			credit_pulses <= credit_pulses + (in_credit ? 1 : 0);
			pixels_sent <= pixels_sent + (in_valid ? 1 : 0);
			if (out_valid)
			begin
				exp_rd <= exp_rd + 1;
				checked <= checked + 1;
			end
		end
	end

	// Downstream returns one credit per received beat, held back in bursts when asked
	always @(posedge clk)
	begin
		#1;
		if (!rst_n)
		begin
			owed = 0;
			out_credit = 1'b0;
		end
		else
		begin
			if (out_valid)
				owed++;
			if (owed > 0 && (!bp_mode || (cycle_count % 48) >= 40))
			begin
				out_credit = 1'b1;
				owed--;
			end
			else
				out_credit = 1'b0;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	check_out_data: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> out_data == exp_mem[exp_rd])
		else
		begin
			errors++;
			$display("mismatch %s: expected %0d actual %0d", test_name,
				exp_mem[exp_rd], out_data);
		end

	check_out_expected: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> exp_rd < exp_wr)
		else
		begin
			errors++;
			$display("%s: an output beat arrived with no result expected", test_name);
		end

	check_out_credit: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> ds_credits > 0)
		else
		begin
			errors++;
			$display("%s: an output beat was sent while no credit was held", test_name);
		end

	check_in_credit: assert property (@(negedge clk) disable iff (!rst_n)
		up_credits <= `IN_CREDITS)
		else
		begin
			errors++;
			$display("%s: more input credits came back than pixels were sent", test_name);
		end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	function automatic int pick_value(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return lo + r % (hi - lo + 1);
	endfunction

	task automatic write_weight(input int f, input int ch, input int tap, input int value);
		host_addr = '0;
		host_addr.weight.region = REGION_WEIGHT;
		host_addr.weight.filter = FILTER_WIDTH'(f);
		host_addr.weight.channel = CHANNEL_WIDTH'(ch);
		host_addr.weight.tap = TAP_WIDTH'(tap);
		host_data = `DATA_WIDTH'(value);
		host_we = 1'b1;
		step();
		host_we = 1'b0;
	endtask

	task automatic write_bias(input int f, input int value);
		host_addr = '0;
		host_addr.bias.region = REGION_BIAS;
		host_addr.bias.filter = FILTER_WIDTH'(f);
		host_data = `DATA_WIDTH'(value);
		host_we = 1'b1;
		step();
		host_we = 1'b0;
	endtask

	task automatic load_filter(input int f);
		for (int ch = 0; ch < `IFM_DEPTH; ch++)
			for (int t = 0; t < WIN_TAPS; t++)
				write_weight(f, ch, t, wt[ch][t]);
		write_bias(f, bias_val);
		filter_sel = FILTER_WIDTH'(f);
	endtask

	task automatic fill_random(input int pix_lo, input int pix_hi,
		input int w_lo, input int w_hi);
		for (int ch = 0; ch < `IFM_DEPTH; ch++)
		begin
			for (int r = 0; r < `IFM_SIZE; r++)
				for (int c = 0; c < `IFM_SIZE; c++)
					pix[ch][r][c] = pick_value(pix_lo, pix_hi);
			for (int t = 0; t < WIN_TAPS; t++)
				wt[ch][t] = pick_value(w_lo, w_hi);
		end
	endtask

	// Bias plus the sum over channels and taps, then ReLU and clamp to the output word
	task automatic queue_expected();
		longint total;
		for (int orow = 0; orow < OUT_SIZE; orow++)
			for (int ocol = 0; ocol < OUT_SIZE; ocol++)
			begin
				total = bias_val;
				for (int ch = 0; ch < `IFM_DEPTH; ch++)
					for (int r = 0; r < `KERNEL_SIZE; r++)
						for (int c = 0; c < `KERNEL_SIZE; c++)
							total += longint'(pix[ch][orow + r][ocol + c])
								* wt[ch][r * `KERNEL_SIZE + c];
				if (total < 0)
					total = 0;
				else if (total > OUT_MAX)
					total = OUT_MAX;
				exp_mem[exp_wr] = `DATA_WIDTH'(total);
				exp_wr++;
			end
	endtask

	// Channel after channel in raster order, one beat per held credit
	task automatic stream_image();
		int burst;
		burst = 0;
		for (int ch = 0; ch < `IFM_DEPTH; ch++)
			for (int r = 0; r < `IFM_SIZE; r++)
				for (int c = 0; c < `IFM_SIZE; c++)
				begin
					while (up_credits == 0)
						step();
					in_valid = 1'b1;
					in_pixel = `DATA_WIDTH'(pix[ch][r][c]);
					step();
					in_valid = 1'b0;
					burst++;
					if (gap_mode && burst == 12)
					begin
						burst = 0;
						repeat (pick_value(1, 6)) step();
					end
				end
	endtask

	task automatic run_pass();
		err_start = errors;
		chk_start = checked;
		queue_expected();
		stream_image();
		while (exp_rd != exp_wr)
			step();
	endtask

	task automatic report_test();
		tests_run++;
		$display("test %s: %0d outputs checked, %0d errors", test_name, checked - chk_start,
			errors - err_start);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_data = '0;
		filter_sel = '0;
		in_valid = 1'b0;
		in_pixel = '0;
		out_credit = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		assert (!in_credit && !out_valid)
		else
		begin
			errors++;
			$display("reset: stream outputs were not low after reset");
		end

		// Decoy coefficients in the neighbouring filters must not leak into filter 5
		test_name = "host_load";
		for (int ch = 0; ch < `IFM_DEPTH; ch++)
			for (int t = 0; t < WIN_TAPS; t++)
				write_weight(4, ch, t, 7);
		write_bias(4, 100);
		write_bias(6, -50);
		fill_random(-100, 100, 0, 0);
		for (int ch = 0; ch < `IFM_DEPTH; ch++)
			wt[ch][WIN_TAPS / 2] = 1; // Center tap only
		bias_val = 37;
		load_filter(5);
		run_pass();
		report_test();

		test_name = "random_conv";
		fill_random(-64, 63, -16, 15);
		bias_val = pick_value(-512, 511);
		load_filter(3);
		run_pass();
		report_test();

		// Top rows drive the sum far above the output range, bottom rows far below zero
		test_name = "relu_saturation";
		fill_random(200, 255, 200, 255);
		for (int ch = 0; ch < `IFM_DEPTH; ch++)
			for (int c = 0; c < `IFM_SIZE; c++)
			begin
				pix[ch][2][c] = pick_value(-10, 10);
				pix[ch][3][c] = -pix[ch][3][c];
				pix[ch][4][c] = -pix[ch][4][c];
			end
		bias_val = pick_value(-100, 100);
		load_filter(1);
		run_pass();
		report_test();

		test_name = "output_backpressure";
		fill_random(-64, 63, -16, 15);
		bias_val = pick_value(-512, 511);
		load_filter(7);
		bp_mode = 1'b1;
		run_pass();
		bp_mode = 1'b0;
		report_test();

		// Every pop comes before the last output, so all credits are back by now
		test_name = "input_credits";
		fill_random(-64, 63, -16, 15);
		bias_val = pick_value(-512, 511);
		load_filter(2);
		gap_mode = 1'b1;
		credit_pulses = 0;
		pixels_sent = 0;
		run_pass();
		gap_mode = 1'b0;
		assert (credit_pulses == pixels_sent)
		else
		begin
			errors++;
			$display("mismatch %s: expected %0d actual %0d", test_name,
				pixels_sent, credit_pulses);
		end
		report_test();

		$display("%0d tests run, %0d outputs checked, %0d errors", tests_run, checked, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== source/conv_layer_top.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_layer_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              host_we,
	input  conv_pkg::host_addr_u              host_addr,
	input  logic signed [`DATA_WIDTH-1:0]     host_data,
	input  logic [conv_pkg::FILTER_WIDTH-1:0] filter_sel,
	input  logic                              in_valid,
	input  logic signed [`DATA_WIDTH-1:0]     in_pixel,
	input  logic                              out_credit,
	output logic                              in_credit,
	output logic                              out_valid,
	output logic signed [`DATA_WIDTH-1:0]     out_data
);
	import conv_pkg::*;

	logic                          stall;
	logic                          win_valid;
	logic signed [`DATA_WIDTH-1:0] win_pixels [WIN_TAPS];
	logic [CHANNEL_WIDTH-1:0]      win_channel;
	logic [POS_WIDTH-1:0]          win_pos;
	logic                          wm_read;
	logic [CHANNEL_WIDTH-1:0]      wm_channel;
	logic [TAP_WIDTH-1:0]          wm_tap;
	logic signed [`DATA_WIDTH-1:0] wm_data [WIN_TAPS];
	logic signed [`DATA_WIDTH-1:0] bias_data;
	logic                          dot_valid;
	logic signed [`ACC_WIDTH-1:0]  dot_value;
	logic [CHANNEL_WIDTH-1:0]      dot_channel;
	logic [POS_WIDTH-1:0]          dot_pos;

	coef_memory coef_memory_inst (
		.clk(clk),
		.rst_n(rst_n),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_data(host_data),
		.filter_sel(filter_sel),
		.wm_channel(wm_channel),
		.wm_tap(wm_tap),
		.wm_read(wm_read),
		.wm_data(wm_data),
		.bias_data(bias_data)
	);

	window_buffer window_buffer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_pixel(in_pixel),
		.stall(stall),
		.in_credit(in_credit),
		.win_valid(win_valid),
		.win_pixels(win_pixels),
		.win_channel(win_channel),
		.win_pos(win_pos)
	);

	mac_unit mac_unit_inst (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.win_valid(win_valid),
		.win_pixels(win_pixels),
		.win_channel(win_channel),
		.win_pos(win_pos),
		.wm_data(wm_data),
		.wm_read(wm_read),
		.wm_channel(wm_channel),
		.wm_tap(wm_tap),
		.dot_valid(dot_valid),
		.dot_value(dot_value),
		.dot_channel(dot_channel),
		.dot_pos(dot_pos)
	);

	bias_accumulator bias_accumulator_inst (
		.clk(clk),
		.rst_n(rst_n),
		.dot_valid(dot_valid),
		.dot_value(dot_value),
		.dot_channel(dot_channel),
		.dot_pos(dot_pos),
		.bias_data(bias_data),
		.out_credit(out_credit),
		.stall(stall),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

// ==== source/bias_accumulator.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module bias_accumulator (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               dot_valid,
	input  logic signed [`ACC_WIDTH-1:0]       dot_value,
	input  logic [conv_pkg::CHANNEL_WIDTH-1:0] dot_channel,
	input  logic [conv_pkg::POS_WIDTH-1:0]     dot_pos,
	input  logic signed [`DATA_WIDTH-1:0]      bias_data,
	input  logic                               out_credit,
	output logic                               stall,
	output logic                               out_valid,
	output logic signed [`DATA_WIDTH-1:0]      out_data
);
	import conv_pkg::*;

	localparam int CREDIT_WIDTH = $clog2(`OUT_CREDITS + 1);
	localparam logic signed [`ACC_WIDTH-1:0] SAT_MAX = `ACC_WIDTH'(2 ** (`DATA_WIDTH - 1) - 1);

	logic signed [`ACC_WIDTH-1:0]  psum_mem [OUT_SIZE * OUT_SIZE];
	logic signed [`ACC_WIDTH-1:0]  psum_base;
	logic signed [`ACC_WIDTH-1:0]  total;
	logic signed [`DATA_WIDTH-1:0] result;
	logic signed [`DATA_WIDTH-1:0] pend_data;
	logic [CREDIT_WIDTH-1:0]       credits;
	logic                          pending;
	logic                          has_credit;
	logic                          accept;
	logic                          last_chan;
	logic                          send_pend;
	logic                          send_new;
	logic                          spend;

	assign has_credit = credits != '0;
	assign stall = pending && !has_credit; // A finished result has nowhere to go
	assign accept = dot_valid && !stall;
	assign last_chan = dot_channel == CHANNEL_WIDTH'(`IFM_DEPTH - 1);
	assign send_pend = pending && has_credit;
	assign send_new = accept && last_chan && has_credit && !pending;
	assign spend = send_pend || send_new;

	always_comb
	begin
		psum_base = (dot_channel == '0) ? '0 : psum_mem[dot_pos]; // Channel 0 starts a fresh sum
		total = psum_base + dot_value + `ACC_WIDTH'(bias_data);
		if (total < 0)
			result = '0;
		else if (total > SAT_MAX)
			result = `DATA_WIDTH'(SAT_MAX);
		else
			result = total[`DATA_WIDTH-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (accept && !last_chan)
			psum_mem[dot_pos] <= psum_base + dot_value;
		if (accept && last_chan && !send_new)
			pend_data <= result;
		if (spend)
			out_data <= send_pend ? pend_data : result;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pending <= 1'b0;
			out_valid <= 1'b0;
			credits <= CREDIT_WIDTH'(`OUT_CREDITS);
		end
		else
		begin
			out_valid <= spend;
			if (accept && last_chan && !send_new)
				pending <= 1'b1;
			else if (send_pend)
				pending <= 1'b0;
			case ({out_credit, spend})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Downstream never returns more credits than it was given
	credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CREDIT_WIDTH'(`OUT_CREDITS))
		else $error("bias_accumulator: output credit count above its initial value");

endmodule

// ==== source/mac_unit.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module mac_unit (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               stall,
	input  logic                               win_valid,
	input  logic signed [`DATA_WIDTH-1:0]      win_pixels [conv_pkg::WIN_TAPS],
	input  logic [conv_pkg::CHANNEL_WIDTH-1:0] win_channel,
	input  logic [conv_pkg::POS_WIDTH-1:0]     win_pos,
	input  logic signed [`DATA_WIDTH-1:0]      wm_data [conv_pkg::WIN_TAPS],
	output logic                               wm_read,
	output logic [conv_pkg::CHANNEL_WIDTH-1:0] wm_channel,
	output logic [conv_pkg::TAP_WIDTH-1:0]     wm_tap,
	output logic                               dot_valid,
	output logic signed [`ACC_WIDTH-1:0]       dot_value,
	output logic [conv_pkg::CHANNEL_WIDTH-1:0] dot_channel,
	output logic [conv_pkg::POS_WIDTH-1:0]     dot_pos
);
	import conv_pkg::*;

	logic                          s1_valid;
	logic signed [`DATA_WIDTH-1:0] s1_pixels [WIN_TAPS];
	logic [CHANNEL_WIDTH-1:0]      s1_channel;
	logic [POS_WIDTH-1:0]          s1_pos;
	logic signed [`ACC_WIDTH-1:0]  dot_sum;

	// Weights are fetched as the window enters stage one
	assign wm_read = win_valid && !stall;
	assign wm_channel = win_channel;
	assign wm_tap = '0; // The fetch always starts at the first tap

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			dot_valid <= 1'b0;
		end
		else if (!stall)
		begin
			s1_valid <= win_valid;
			dot_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall && win_valid)
		begin
			s1_pixels <= win_pixels;
			s1_channel <= win_channel;
			s1_pos <= win_pos;
		end
		if (!stall && s1_valid)
		begin
			dot_value <= dot_sum;
			dot_channel <= s1_channel;
			dot_pos <= s1_pos;
		end
	end

	// Full-width products, summed at accumulator width
	always_comb
	begin
		dot_sum = '0;
		for (int t = 0; t < WIN_TAPS; t++)
			dot_sum = dot_sum + s1_pixels[t] * wm_data[t];
	end

endmodule

// ==== source/window_buffer.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module window_buffer (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               in_valid,
	input  logic signed [`DATA_WIDTH-1:0]      in_pixel,
	input  logic                               stall,
	output logic                               in_credit,
	output logic                               win_valid,
	output logic signed [`DATA_WIDTH-1:0]      win_pixels [conv_pkg::WIN_TAPS],
	output logic [conv_pkg::CHANNEL_WIDTH-1:0] win_channel,
	output logic [conv_pkg::POS_WIDTH-1:0]     win_pos
);
	import conv_pkg::*;

	localparam int LINE_LEN    = (`KERNEL_SIZE - 1) * `IFM_SIZE + `KERNEL_SIZE;
	localparam int PTR_WIDTH   = $clog2(`IN_CREDITS);
	localparam int COUNT_WIDTH = $clog2(`IN_CREDITS + 1);
	localparam int COORD_WIDTH = $clog2(`IFM_SIZE);

	logic signed [`DATA_WIDTH-1:0] fifo_mem [`IN_CREDITS];
	logic [PTR_WIDTH-1:0]          wr_ptr;
	logic [PTR_WIDTH-1:0]          rd_ptr;
	logic [COUNT_WIDTH-1:0]        fifo_count;
	logic                          pop;
	logic signed [`DATA_WIDTH-1:0] line [LINE_LEN];
	logic [COORD_WIDTH-1:0]        col;
	logic [COORD_WIDTH-1:0]        row;
	logic [CHANNEL_WIDTH-1:0]      channel;
	logic                          at_window;

	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(`IN_CREDITS - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pop = (fifo_count != '0) && !stall;
	assign at_window = (row >= COORD_WIDTH'(`KERNEL_SIZE - 1))
		&& (col >= COORD_WIDTH'(`KERNEL_SIZE - 1));

	always_ff @(posedge clk)
	begin
		if (in_valid)
			fifo_mem[wr_ptr] <= in_pixel;
		if (pop)
		begin
			line[0] <= fifo_mem[rd_ptr]; // Newest pixel sits at the head of the line
			for (int i = 1; i < LINE_LEN; i++)
				line[i] <= line[i-1];
			win_channel <= channel;
			win_pos <= POS_WIDTH'((row - (`KERNEL_SIZE - 1)) * OUT_SIZE
				+ (col - (`KERNEL_SIZE - 1)));
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
			in_credit <= 1'b0;
			win_valid <= 1'b0;
			col <= '0;
			row <= '0;
			channel <= '0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({in_valid, pop})
				2'b10: fifo_count <= fifo_count + 1'b1;
				2'b01: fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;
			endcase
			in_credit <= pop; // One credit back per pixel taken out
			if (!stall)
				win_valid <= pop && at_window;
			if (pop)
			begin
				if (col == COORD_WIDTH'(`IFM_SIZE - 1))
				begin
					col <= '0;
					if (row == COORD_WIDTH'(`IFM_SIZE - 1))
					begin
						row <= '0;
						channel <= (channel == CHANNEL_WIDTH'(`IFM_DEPTH - 1)) ? '0 : channel + 1'b1;
					end
					else
						row <= row + 1'b1;
				end
				else
					col <= col + 1'b1;
			end
		end
	end

	// Tap r*K+c is the pixel (K-1-r) rows and (K-1-c) columns behind the newest
	always_comb
	begin
		for (int r = 0; r < `KERNEL_SIZE; r++)
			for (int c = 0; c < `KERNEL_SIZE; c++)
				win_pixels[r * `KERNEL_SIZE + c] =
					line[(`KERNEL_SIZE - 1 - r) * `IFM_SIZE + (`KERNEL_SIZE - 1 - c)];
	end

	credit_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> fifo_count < COUNT_WIDTH'(`IN_CREDITS))
		else $error("window_buffer: pixel arrived with the input FIFO full");

endmodule

// ==== source/coef_memory.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module coef_memory (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              host_we,
	input  conv_pkg::host_addr_u              host_addr,
	input  logic signed [`DATA_WIDTH-1:0]     host_data,
	input  logic [conv_pkg::FILTER_WIDTH-1:0] filter_sel,
	input  logic [conv_pkg::CHANNEL_WIDTH-1:0] wm_channel,
	input  logic [conv_pkg::TAP_WIDTH-1:0]    wm_tap,
	input  logic                              wm_read,
	output logic signed [`DATA_WIDTH-1:0]     wm_data [conv_pkg::WIN_TAPS],
	output logic signed [`DATA_WIDTH-1:0]     bias_data
);
	import conv_pkg::*;

	logic signed [`DATA_WIDTH-1:0] weight_mem [WM_DEPTH];
	logic signed [`DATA_WIDTH-1:0] bias_mem [`NUM_FILTERS];
	logic [WM_ADDR_WIDTH-1:0]      host_waddr;
	logic [WM_ADDR_WIDTH-1:0]      read_base;
	logic                          host_tap_ok;

	// Weights are laid out filter, then channel, then tap
	assign host_waddr = WM_ADDR_WIDTH'((host_addr.weight.filter * `IFM_DEPTH
		+ host_addr.weight.channel) * WIN_TAPS + host_addr.weight.tap);
	assign host_tap_ok = host_addr.weight.tap < TAP_WIDTH'(WIN_TAPS);

	assign read_base = WM_ADDR_WIDTH'((filter_sel * `IFM_DEPTH + wm_channel) * WIN_TAPS
		+ wm_tap);

	always_ff @(posedge clk)
	begin
		if (host_we)
		begin
			if (host_addr.weight.region == REGION_WEIGHT)
			begin
				if (host_tap_ok) // Tap codes past the window are dropped
					weight_mem[host_waddr] <= host_data;
			end
			else
			begin
				bias_mem[host_addr.bias.filter] <= host_data;
			end
		end
	end

	// The whole window of weights comes out one cycle after the read
	always_ff @(posedge clk)
	begin
		if (wm_read)
		begin
			for (int t = 0; t < WIN_TAPS; t++)
				wm_data[t] <= weight_mem[read_base + WM_ADDR_WIDTH'(t)];
		end
	end

	assign bias_data = bias_mem[filter_sel];

	// Coefficients may only change while the stream is idle
	host_write_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!(host_we && wm_read))
		else $error("coef_memory: host write collided with a weight read");

endmodule

// ==== source/conv_pkg.sv ====
`include "conv_settings.svh"

package conv_pkg;

	localparam int OUT_SIZE      = `IFM_SIZE - `KERNEL_SIZE + 1;
	localparam int WIN_TAPS      = `KERNEL_SIZE * `KERNEL_SIZE;
	localparam int WM_DEPTH      = WIN_TAPS * `IFM_DEPTH * `NUM_FILTERS;
	localparam int WM_ADDR_WIDTH = $clog2(WM_DEPTH);
	localparam int FILTER_WIDTH  = $clog2(`NUM_FILTERS);
	localparam int CHANNEL_WIDTH = $clog2(`IFM_DEPTH);
	localparam int TAP_WIDTH     = $clog2(WIN_TAPS);
	localparam int POS_WIDTH     = $clog2(OUT_SIZE * OUT_SIZE);

	// Unused bits between the region bit and the index in each view
	localparam int W_PAD_WIDTH = `HOST_ADDR_WIDTH - 1 - FILTER_WIDTH - CHANNEL_WIDTH - TAP_WIDTH;
	localparam int B_PAD_WIDTH = `HOST_ADDR_WIDTH - 1 - FILTER_WIDTH;

	localparam logic REGION_WEIGHT = 1'b0;
	localparam logic REGION_BIAS   = 1'b1;

	typedef struct packed {
		logic                     region;
		logic [W_PAD_WIDTH-1:0]   pad;
		logic [FILTER_WIDTH-1:0]  filter;
		logic [CHANNEL_WIDTH-1:0] channel;
		logic [TAP_WIDTH-1:0]     tap;
	} host_weight_t;

	typedef struct packed {
		logic                    region;
		logic [B_PAD_WIDTH-1:0]  pad;
		logic [FILTER_WIDTH-1:0] filter;
	} host_bias_t;

	// Same host word read as a weight index or as a bias index
	typedef union packed {
		host_weight_t weight;
		host_bias_t   bias;
	} host_addr_u;

endpackage

// ==== source/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Feature map geometry
`define IFM_SIZE        5
`define KERNEL_SIZE     3
`define IFM_DEPTH       4

// One filter is computed per pass, chosen by the host
`define NUM_FILTERS     8

// Signed pixel, weight and output words
`define DATA_WIDTH      16
`define ACC_WIDTH       32

// Top bit of the host address picks weights or bias
`define HOST_ADDR_WIDTH 12

// Input FIFO depth, which is also the upstream credit count after reset
`define IN_CREDITS      4

// Output beats allowed before downstream returns a credit
`define OUT_CREDITS     2

`endif
